//--- hw/core_pkg.sv
package core_pkg;

    import isa_pkg::*;

    localparam int ftq_id_w = 3;

    // Valid sits on top so a zeroed record is an empty slot
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       instr;
        logic                  is_last_in_block;
        logic [ftq_id_w-1:0]   ftq_id;
        logic [FE_EXCP_W-1:0]  fe_excp;
    } instr_buffer_info_t;

    // Index 0 is rj, index 1 is rk or rd
    typedef struct packed {
        logic                             hit;
        logic [ALUOP_W-1:0]               aluop;
        logic [ALUSEL_W-1:0]              alusel;
        logic [1:0]                       reg_read_valid;
        logic [1:0][REG_ADDR_W-1:0]       reg_read_addr;
        logic                             reg_write_valid;
        logic [REG_ADDR_W-1:0]            reg_write_addr;
        logic                             use_imm;
        logic [XLEN-1:0]                  imm;
    } decode_result_t;

    typedef struct packed {
        logic                 ipe;
        logic                 ine;
        logic                 brk;
        logic                 syscall;
        logic [FE_EXCP_W-1:0] fe;
        logic                 intr;
    } excp_vec_t;

    typedef struct packed {
        instr_buffer_info_t           instr_info;
        logic [ALUOP_W-1:0]           aluop;
        logic [ALUSEL_W-1:0]          alusel;
        logic [1:0]                   reg_read_valid;
        logic [1:0][REG_ADDR_W-1:0]   reg_read_addr;
        logic                         reg_write_valid;
        logic [REG_ADDR_W-1:0]        reg_write_addr;
        logic                         use_imm;
        logic [XLEN-1:0]              imm;
        logic                         excp;
        excp_vec_t                    excp_num;
    } id_dispatch_t;

endpackage

//--- hw/decoder_2ri12.sv
module decoder_2ri12
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic [XLEN-1:0] instr_i,
    output decode_result_t  result_o
);

    logic [9:0]          opcode;
    logic [11:0]         si12;
    logic [ALUOP_W-1:0]  aluop;
    logic [ALUSEL_W-1:0] alusel;
    logic                zero_ext;
    logic                is_store;

    assign opcode = instr_i[31:22];
    assign si12   = instr_i[imm_lsb +: 12];

    always_comb begin
        case (opcode)
            opc_slti:   {aluop, alusel} = {exe_slti_op, sel_arith};
            opc_addi_w: {aluop, alusel} = {exe_addi_op, sel_arith};
            opc_andi:   {aluop, alusel} = {exe_andi_op, sel_logic};
            opc_ori:    {aluop, alusel} = {exe_ori_op, sel_logic};
            opc_ld_w:   {aluop, alusel} = {exe_ld_w_op, sel_mem};
            opc_st_w:   {aluop, alusel} = {exe_st_w_op, sel_mem};
            default:    {aluop, alusel} = '0;
        endcase
    end

    // Logic immediates are unsigned
    assign zero_ext = (aluop == exe_andi_op) || (aluop == exe_ori_op);
    assign is_store = aluop == exe_st_w_op;

    always_comb begin
        result_o = '0;
        if (aluop != '0) begin
            result_o.hit              = 1'b1;
            result_o.aluop            = aluop;
            result_o.alusel           = alusel;
            result_o.use_imm          = 1'b1;
            result_o.imm              = zero_ext ? {{(XLEN-12){1'b0}}, si12}
                                                 : {{(XLEN-12){si12[11]}}, si12};
            result_o.reg_read_valid   = {is_store, 1'b1};
            result_o.reg_read_addr[0] = instr_i[rj_lsb +: REG_ADDR_W];
            // Store data comes from rd
            if (is_store) begin
                result_o.reg_read_addr[1] = instr_i[rd_lsb +: REG_ADDR_W];
            end else begin
                result_o.reg_write_valid = 1'b1;
                result_o.reg_write_addr  = instr_i[rd_lsb +: REG_ADDR_W];
            end
        end
    end

endmodule

//--- hw/decoder_3r.sv
module decoder_3r
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic [XLEN-1:0] instr_i,
    output decode_result_t  result_o
);

    logic [16:0]         opcode;
    logic [ALUOP_W-1:0]  aluop;
    logic [ALUSEL_W-1:0] alusel;
    logic                hit;
    logic                sys_op;

    assign opcode = instr_i[31:15];

    always_comb begin
        case (opcode)
            opc_add_w:   {aluop, alusel} = {exe_add_op, sel_arith};
            opc_sub_w:   {aluop, alusel} = {exe_sub_op, sel_arith};
            opc_slt:     {aluop, alusel} = {exe_slt_op, sel_arith};
            opc_sltu:    {aluop, alusel} = {exe_sltu_op, sel_arith};
            opc_and:     {aluop, alusel} = {exe_and_op, sel_logic};
            opc_or:      {aluop, alusel} = {exe_or_op, sel_logic};
            opc_xor:     {aluop, alusel} = {exe_xor_op, sel_logic};
            opc_break:   {aluop, alusel} = {exe_break_op, sel_nop};
            opc_syscall: {aluop, alusel} = {exe_syscall_op, sel_nop};
            default:     {aluop, alusel} = '0;
        endcase
    end

    assign hit    = aluop != '0;
    assign sys_op = (aluop == exe_break_op) || (aluop == exe_syscall_op);

    always_comb begin
        result_o        = '0;
        result_o.hit    = hit;
        result_o.aluop  = aluop;
        result_o.alusel = alusel;
        if (sys_op) begin
            // 15-bit code field, no registers touched
            result_o.imm = {{(XLEN-15){1'b0}}, instr_i[14:0]};
        end else if (hit) begin
            result_o.reg_read_valid   = 2'b11;
            result_o.reg_read_addr[0] = instr_i[rj_lsb +: REG_ADDR_W];
            result_o.reg_read_addr[1] = instr_i[rk_lsb +: REG_ADDR_W];
            result_o.reg_write_valid  = 1'b1;
            result_o.reg_write_addr   = instr_i[rd_lsb +: REG_ADDR_W];
        end
    end

endmodule

//--- hw/decoder_csr.sv
module decoder_csr
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic [XLEN-1:0] instr_i,
    output decode_result_t  result_o
);

    logic [REG_ADDR_W-1:0] rj;
    logic [REG_ADDR_W-1:0] rd;
    logic                  is_csr;

    assign rj     = instr_i[rj_lsb +: REG_ADDR_W];
    assign rd     = instr_i[rd_lsb +: REG_ADDR_W];
    assign is_csr = instr_i[31:24] == opc_csr;

    always_comb begin
        result_o = '0;
        if (is_csr) begin
            result_o.hit             = 1'b1;
            result_o.alusel          = sel_csr;
            result_o.use_imm         = 1'b1;
            result_o.imm             = {{(XLEN-14){1'b0}}, instr_i[imm_lsb +: 14]};
            result_o.reg_write_valid = 1'b1;
            result_o.reg_write_addr  = rd;
            // rj picks the access kind
            case (rj)
                5'd0: result_o.aluop = exe_csrrd_op;
                5'd1: begin
                    result_o.aluop            = exe_csrwr_op;
                    result_o.reg_read_valid   = 2'b10;
                    result_o.reg_read_addr[1] = rd;
                end
                default: begin
                    result_o.aluop          = exe_csrxchg_op;
                    result_o.reg_read_valid = 2'b11;
                    result_o.reg_read_addr  = {rd, rj};
                end
            endcase
        end else if (instr_i == opc_ertn || instr_i == opc_idle) begin
            result_o.hit    = 1'b1;
            result_o.aluop  = (instr_i == opc_ertn) ? exe_ertn_op : exe_idle_op;
            result_o.alusel = sel_csr;
        end
    end

endmodule

//--- hw/decoder_long_imm.sv
module decoder_long_imm
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic [XLEN-1:0] instr_i,
    output decode_result_t  result_o
);

    logic [6:0]  op_1ri20;
    logic [5:0]  op_i26;
    logic [25:0] offs26;

    assign op_1ri20 = instr_i[31:25];
    assign op_i26   = instr_i[31:26];
    // High ten bits of the offset sit in the low field
    assign offs26   = {instr_i[9:0], instr_i[imm_lsb +: 16]};

    always_comb begin
        result_o = '0;
        if (op_1ri20 == opc_lu12i_w || op_1ri20 == opc_pcaddu12i) begin
            result_o.hit             = 1'b1;
            result_o.aluop           = (op_1ri20 == opc_lu12i_w) ? exe_lu12i_op
                                                                 : exe_pcaddu12i_op;
            result_o.alusel          = sel_arith;
            result_o.use_imm         = 1'b1;
            result_o.imm             = {instr_i[24:5], 12'b0};
            result_o.reg_write_valid = 1'b1;
            result_o.reg_write_addr  = instr_i[rd_lsb +: REG_ADDR_W];
        end else if (op_i26 == opc_b || op_i26 == opc_bl) begin
            result_o.hit     = 1'b1;
            result_o.aluop   = (op_i26 == opc_bl) ? exe_bl_op : exe_b_op;
            result_o.alusel  = sel_branch;
            result_o.use_imm = 1'b1;
            result_o.imm     = {{(XLEN-28){offs26[25]}}, offs26, 2'b00};
            // bl links into ra
            result_o.reg_write_valid = op_i26 == opc_bl;
            result_o.reg_write_addr  = (op_i26 == opc_bl) ? reg_ra : '0;
        end
    end

endmodule

//--- hw/id.sv
module id
    import isa_pkg::*;
    import core_pkg::*;
(
    input  instr_buffer_info_t ib_i,
    input  logic               has_int_i,
    input  logic [1:0]         csr_plv_i,
    output id_dispatch_t       dispatch_o
);

    decode_result_t     res_3r;
    decode_result_t     res_2ri12;
    decode_result_t     res_long_imm;
    decode_result_t     res_csr;
    decode_result_t     merged;
    decode_result_t     dec;
    instr_buffer_info_t info;
    logic               kernel_op;
    logic [EXCP_W-1:0]  excp_bits;

    decoder_3r u_decoder_3r (
        .instr_i  (ib_i.instr),
        .result_o (res_3r)
    );

    decoder_2ri12 u_decoder_2ri12 (
        .instr_i  (ib_i.instr),
        .result_o (res_2ri12)
    );

    decoder_long_imm u_decoder_long_imm (
        .instr_i  (ib_i.instr),
        .result_o (res_long_imm)
    );

    decoder_csr u_decoder_csr (
        .instr_i  (ib_i.instr),
        .result_o (res_csr)
    );

    // Non-matching decoders drive zeros, so OR merges them
    assign merged = res_3r | res_2ri12 | res_long_imm | res_csr;
    assign dec    = (ib_i.valid && merged.hit) ? merged : '0;
    assign info   = ib_i.valid ? ib_i : '0;

    assign kernel_op = dec.aluop inside {exe_csrrd_op, exe_csrwr_op, exe_csrxchg_op,
                                         exe_ertn_op, exe_idle_op};

    always_comb begin
        excp_bits                               = '0;
        excp_bits[excp_ipe_bit]                 = kernel_op && (csr_plv_i == PLV_USER);
        excp_bits[excp_ine_bit]                 = ib_i.valid && !merged.hit;
        excp_bits[excp_break_bit]               = dec.aluop == exe_break_op;
        excp_bits[excp_syscall_bit]             = dec.aluop == exe_syscall_op;
        excp_bits[excp_fe_lsb +: FE_EXCP_W]     = info.fe_excp;
        // No interrupt is taken on an empty slot
        excp_bits[excp_int_bit]                 = ib_i.valid && has_int_i;
    end

    always_comb begin
        dispatch_o.instr_info      = info;
        dispatch_o.aluop           = dec.aluop;
        dispatch_o.alusel          = dec.alusel;
        dispatch_o.reg_read_valid  = dec.reg_read_valid;
        dispatch_o.reg_read_addr   = dec.reg_read_addr;
        dispatch_o.reg_write_valid = dec.reg_write_valid;
        dispatch_o.reg_write_addr  = dec.reg_write_addr;
        dispatch_o.use_imm         = dec.use_imm;
        dispatch_o.imm             = dec.imm;
        dispatch_o.excp            = ib_i.valid && (|excp_bits);
        dispatch_o.excp_num        = excp_bits;
    end

endmodule

//--- hw/id_stage.sv
module id_stage
    import core_pkg::*;
(
    input  logic               clk,
    input  logic               reset_i,
    input  instr_buffer_info_t ib_i,
    input  logic               stall_i,
    input  logic               flush_i,
    input  logic               has_int_i,
    input  logic [1:0]         csr_plv_i,
    output id_dispatch_t       dispatch_o
);

    instr_buffer_info_t slot;
    id_dispatch_t       dec;

    // Instruction buffer slot
    stage_reg #(.payload_t(instr_buffer_info_t)) u_slot_reg (
        .clk     (clk),
        .reset_i (reset_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .d_i     (ib_i),
        .q_o     (slot)
    );

    id u_id (
        .ib_i       (slot),
        .has_int_i  (has_int_i),
        .csr_plv_i  (csr_plv_i),
        .dispatch_o (dec)
    );

    stage_reg #(.payload_t(id_dispatch_t)) u_dispatch_reg (
        .clk     (clk),
        .reset_i (reset_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .d_i     (dec),
        .q_o     (dispatch_o)
    );

endmodule

//--- hw/isa_pkg.sv
package isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALUOP_W    = 8;
    localparam int ALUSEL_W   = 3;
    localparam int EXCP_W     = 9;
    localparam int FE_EXCP_W  = 4;

    localparam logic [1:0] PLV_USER = 2'd3;

    // Register fields, immediates of 2RI12, CSR and I26 start at imm_lsb
    localparam int rd_lsb  = 0;
    localparam int rj_lsb  = 5;
    localparam int rk_lsb  = 10;
    localparam int imm_lsb = 10;

    // Link register written by bl
    localparam logic [REG_ADDR_W-1:0] reg_ra = 5'd1;

    // 3R major opcodes, instr[31:15]
    localparam logic [16:0] opc_add_w   = 17'h00020;
    localparam logic [16:0] opc_sub_w   = 17'h00022;
    localparam logic [16:0] opc_slt     = 17'h00024;
    localparam logic [16:0] opc_sltu    = 17'h00025;
    localparam logic [16:0] opc_and     = 17'h00029;
    localparam logic [16:0] opc_or      = 17'h0002a;
    localparam logic [16:0] opc_xor     = 17'h0002b;
    localparam logic [16:0] opc_break   = 17'h00054;
    localparam logic [16:0] opc_syscall = 17'h00056;

    // 2RI12 opcodes, instr[31:22]
    localparam logic [9:0] opc_slti   = 10'h008;
    localparam logic [9:0] opc_addi_w = 10'h00a;
    localparam logic [9:0] opc_andi   = 10'h00d;
    localparam logic [9:0] opc_ori    = 10'h00e;
    localparam logic [9:0] opc_ld_w   = 10'h0a2;
    localparam logic [9:0] opc_st_w   = 10'h0a6;

    // 1RI20 in instr[31:25], I26 in instr[31:26]
    localparam logic [6:0] opc_lu12i_w   = 7'h0a;
    localparam logic [6:0] opc_pcaddu12i = 7'h0e;
    localparam logic [5:0] opc_b         = 6'h14;
    localparam logic [5:0] opc_bl        = 6'h15;

    // CSR access in instr[31:24]; ertn and idle are whole words
    localparam logic [7:0]  opc_csr  = 8'h04;
    localparam logic [31:0] opc_ertn = 32'h0648_3800;
    localparam logic [31:0] opc_idle = 32'h0648_8000;

    // ALU operations, zero means no operation
    localparam logic [ALUOP_W-1:0] exe_add_op       = 8'd1;
    localparam logic [ALUOP_W-1:0] exe_sub_op       = 8'd2;
    localparam logic [ALUOP_W-1:0] exe_slt_op       = 8'd3;
    localparam logic [ALUOP_W-1:0] exe_sltu_op      = 8'd4;
    localparam logic [ALUOP_W-1:0] exe_and_op       = 8'd5;
    localparam logic [ALUOP_W-1:0] exe_or_op        = 8'd6;
    localparam logic [ALUOP_W-1:0] exe_xor_op       = 8'd7;
    localparam logic [ALUOP_W-1:0] exe_break_op     = 8'd8;
    localparam logic [ALUOP_W-1:0] exe_syscall_op   = 8'd9;
    localparam logic [ALUOP_W-1:0] exe_addi_op      = 8'd10;
    localparam logic [ALUOP_W-1:0] exe_slti_op      = 8'd11;
    localparam logic [ALUOP_W-1:0] exe_andi_op      = 8'd12;
    localparam logic [ALUOP_W-1:0] exe_ori_op       = 8'd13;
    localparam logic [ALUOP_W-1:0] exe_ld_w_op      = 8'd14;
    localparam logic [ALUOP_W-1:0] exe_st_w_op      = 8'd15;
    localparam logic [ALUOP_W-1:0] exe_lu12i_op     = 8'd16;
    localparam logic [ALUOP_W-1:0] exe_pcaddu12i_op = 8'd17;
    localparam logic [ALUOP_W-1:0] exe_b_op         = 8'd18;
    localparam logic [ALUOP_W-1:0] exe_bl_op        = 8'd19;
    localparam logic [ALUOP_W-1:0] exe_csrrd_op     = 8'd20;
    localparam logic [ALUOP_W-1:0] exe_csrwr_op     = 8'd21;
    localparam logic [ALUOP_W-1:0] exe_csrxchg_op   = 8'd22;
    localparam logic [ALUOP_W-1:0] exe_ertn_op      = 8'd23;
    localparam logic [ALUOP_W-1:0] exe_idle_op      = 8'd24;

    // Result unit selectors
    localparam logic [ALUSEL_W-1:0] sel_nop    = 3'd0;
    localparam logic [ALUSEL_W-1:0] sel_arith  = 3'd1;
    localparam logic [ALUSEL_W-1:0] sel_logic  = 3'd2;
    localparam logic [ALUSEL_W-1:0] sel_mem    = 3'd3;
    localparam logic [ALUSEL_W-1:0] sel_branch = 3'd4;
    localparam logic [ALUSEL_W-1:0] sel_csr    = 3'd5;

    // Exception vector bit positions
    localparam int excp_int_bit     = 0;
    localparam int excp_fe_lsb      = 1;
    localparam int excp_syscall_bit = 5;
    localparam int excp_break_bit   = 6;
    localparam int excp_ine_bit     = 7;
    localparam int excp_ipe_bit     = 8;

endpackage

//--- hw/stage_reg.sv
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     stall_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // Flush wins over stall and empties the whole record
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            q_o <= '0;
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_id_stage \
    --Mdir obj_dir -o sim_id_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_id_stage > sim.log 2>&1
status=$?
cat sim.log

if grep -qx "Finished with errors" sim.log; then
    echo "FAIL"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
echo "PASS"
exit 0

//--- sim/tb_id_stage.sv
module tb_id_stage
    import isa_pkg::*;
    import core_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // Roughly 1000 instructions plus stalls, flushes and drains, with margin
    localparam int max_cycles = 3000;

    logic               clk;
    logic               reset_i;
    instr_buffer_info_t ib_i;
    logic               stall_i;
    logic               flush_i;
    logic               has_int_i;
    logic [1:0]         csr_plv_i;
    id_dispatch_t       dispatch_o;

    integer             seed = 67494;
    int                 cycles = 0;
    id_dispatch_t       exp_q [$];

    id_stage u_dut (
        .clk        (clk),
        .reset_i    (reset_i),
        .ib_i       (ib_i),
        .stall_i    (stall_i),
        .flush_i    (flush_i),
        .has_int_i  (has_int_i),
        .csr_plv_i  (csr_plv_i),
        .dispatch_o (dispatch_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    function automatic logic [31:0] rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r;
    endfunction

    // Instruction word for one of the 24 supported kinds, random fields
    function automatic logic [31:0] make_instr(input int kind);
        logic [31:0] r;
        logic [4:0]  rj;
        r = rand_word();
        case (kind)
            0:  return {opc_add_w, r[14:0]};
            1:  return {opc_sub_w, r[14:0]};
            2:  return {opc_slt, r[14:0]};
            3:  return {opc_sltu, r[14:0]};
            4:  return {opc_and, r[14:0]};
            5:  return {opc_or, r[14:0]};
            6:  return {opc_xor, r[14:0]};
            7:  return {opc_break, r[14:0]};
            8:  return {opc_syscall, r[14:0]};
            9:  return {opc_slti, r[21:0]};
            10: return {opc_addi_w, r[21:0]};
            11: return {opc_andi, r[21:0]};
            12: return {opc_ori, r[21:0]};
            13: return {opc_ld_w, r[21:0]};
            14: return {opc_st_w, r[21:0]};
            15: return {opc_lu12i_w, r[24:0]};
            16: return {opc_pcaddu12i, r[24:0]};
            17: return {opc_b, r[25:0]};
            18: return {opc_bl, r[25:0]};
            19: return {opc_csr, r[23:10], 5'd0, r[4:0]};
            20: return {opc_csr, r[23:10], 5'd1, r[4:0]};
            21: begin
                // csrxchg needs rj above 1
                rj = (r[9:5] < 5'd2) ? 5'd2 : r[9:5];
                return {opc_csr, r[23:10], rj, r[4:0]};
            end
            22: return opc_ertn;
            default: return opc_idle;
        endcase
    endfunction

    // Operation named by the encoding, zero when nothing matches
    function automatic logic [ALUOP_W-1:0] ref_aluop(input logic [31:0] w);
        if (w == opc_ertn) return exe_ertn_op;
        if (w == opc_idle) return exe_idle_op;
        if (w[31:24] == opc_csr) begin
            if (w[9:5] == 5'd0) return exe_csrrd_op;
            if (w[9:5] == 5'd1) return exe_csrwr_op;
            return exe_csrxchg_op;
        end
        case (w[31:15])
            opc_add_w:   return exe_add_op;
            opc_sub_w:   return exe_sub_op;
            opc_slt:     return exe_slt_op;
            opc_sltu:    return exe_sltu_op;
            opc_and:     return exe_and_op;
            opc_or:      return exe_or_op;
            opc_xor:     return exe_xor_op;
            opc_break:   return exe_break_op;
            opc_syscall: return exe_syscall_op;
            default:     ;
        endcase
        case (w[31:22])
            opc_slti:   return exe_slti_op;
            opc_addi_w: return exe_addi_op;
            opc_andi:   return exe_andi_op;
            opc_ori:    return exe_ori_op;
            opc_ld_w:   return exe_ld_w_op;
            opc_st_w:   return exe_st_w_op;
            default:    ;
        endcase
        if (w[31:25] == opc_lu12i_w) return exe_lu12i_op;
        if (w[31:25] == opc_pcaddu12i) return exe_pcaddu12i_op;
        if (w[31:26] == opc_b) return exe_b_op;
        if (w[31:26] == opc_bl) return exe_bl_op;
        return '0;
    endfunction

    function automatic logic [ALUSEL_W-1:0] ref_sel(input logic [ALUOP_W-1:0] op);
        case (op)
            exe_add_op, exe_sub_op, exe_slt_op, exe_sltu_op, exe_addi_op,
            exe_slti_op, exe_lu12i_op, exe_pcaddu12i_op:            return sel_arith;
            exe_and_op, exe_or_op, exe_xor_op, exe_andi_op, exe_ori_op: return sel_logic;
            exe_ld_w_op, exe_st_w_op:                               return sel_mem;
            exe_b_op, exe_bl_op:                                    return sel_branch;
            exe_csrrd_op, exe_csrwr_op, exe_csrxchg_op, exe_ertn_op,
            exe_idle_op:                                            return sel_csr;
            default:                                                return sel_nop;
        endcase
    endfunction

    // Expected dispatch record for one buffer slot
    function automatic id_dispatch_t ref_dispatch(input instr_buffer_info_t ib,
                                                  input logic [1:0] plv, input logic intr);
        id_dispatch_t       e;
        logic [31:0]        w;
        logic [ALUOP_W-1:0] op;
        e  = '0;
        w  = ib.instr;
        op = ref_aluop(w);
        if (!ib.valid) return e;
        e.instr_info = ib;
        e.aluop      = op;
        e.alusel     = ref_sel(op);
        case (op)
            exe_add_op, exe_sub_op, exe_slt_op, exe_sltu_op, exe_and_op, exe_or_op,
            exe_xor_op: begin
                e.reg_read_valid   = 2'b11;
                e.reg_read_addr[0] = w[9:5];
                e.reg_read_addr[1] = w[14:10];
                e.reg_write_valid  = 1'b1;
                e.reg_write_addr   = w[4:0];
            end
            exe_break_op, exe_syscall_op: e.imm = {17'b0, w[14:0]};
            exe_addi_op, exe_slti_op, exe_andi_op, exe_ori_op, exe_ld_w_op,
            exe_st_w_op: begin
                e.use_imm = 1'b1;
                e.imm     = {{20{w[21]}}, w[21:10]};
                if (op == exe_andi_op || op == exe_ori_op) e.imm[31:12] = '0;
                e.reg_read_valid[0] = 1'b1;
                e.reg_read_addr[0]  = w[9:5];
                if (op == exe_st_w_op) begin
                    e.reg_read_valid[1] = 1'b1;
                    e.reg_read_addr[1]  = w[4:0];
                end else begin
                    e.reg_write_valid = 1'b1;
                    e.reg_write_addr  = w[4:0];
                end
            end
            exe_lu12i_op, exe_pcaddu12i_op: begin
                e.use_imm         = 1'b1;
                e.imm             = {w[24:5], 12'b0};
                e.reg_write_valid = 1'b1;
                e.reg_write_addr  = w[4:0];
            end
            exe_b_op, exe_bl_op: begin
                e.use_imm         = 1'b1;
                e.imm             = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
                e.reg_write_valid = (op == exe_bl_op);
                e.reg_write_addr  = (op == exe_bl_op) ? 5'd1 : 5'd0;
            end
            exe_csrrd_op, exe_csrwr_op, exe_csrxchg_op: begin
                e.use_imm         = 1'b1;
                e.imm             = {18'b0, w[23:10]};
                e.reg_write_valid = 1'b1;
                e.reg_write_addr  = w[4:0];
                if (op != exe_csrrd_op) begin
                    e.reg_read_valid[1] = 1'b1;
                    e.reg_read_addr[1]  = w[4:0];
                end
                if (op == exe_csrxchg_op) begin
                    e.reg_read_valid[0] = 1'b1;
                    e.reg_read_addr[0]  = w[9:5];
                end
            end
            default: ;
        endcase
        e.excp_num.ipe     = (op inside {exe_csrrd_op, exe_csrwr_op, exe_csrxchg_op,
                                         exe_ertn_op, exe_idle_op}) && (plv == PLV_USER);
        e.excp_num.ine     = (op == '0);
        e.excp_num.brk     = (op == exe_break_op);
        e.excp_num.syscall = (op == exe_syscall_op);
        e.excp_num.fe      = ib.fe_excp;
        e.excp_num.intr    = intr;
        e.excp             = |e.excp_num;
        return e;
    endfunction

    task automatic check_dispatch(input id_dispatch_t got, input id_dispatch_t want);
        if (got !== want) begin
            $display("error %0t ns: dispatch of instr %h is %h, expected %h",
                     $time, want.instr_info.instr, got, want);
            abort_run();
        end
    endtask

    task automatic check_excp(input excp_vec_t got, input excp_vec_t want);
        if (got !== want) begin
            $display("error %0t ns: exception vector is %b, expected %b", $time, got, want);
            abort_run();
        end
    endtask

    // Present one instruction until a cycle without stall takes it
    task automatic send(input logic [31:0] word, input logic [3:0] fe, input bit use_stall);
        instr_buffer_info_t ib;
        logic [31:0]        r;
        bit                 taken;
        r                   = rand_word();
        ib                  = '0;
        ib.valid            = 1'b1;
        ib.pc               = {r[31:2], 2'b00};
        ib.instr            = word;
        ib.is_last_in_block = r[0];
        ib.ftq_id           = r[4:2];
        ib.fe_excp          = fe;
        taken               = 1'b0;
        while (!taken) begin
            @(negedge clk);
            r       = rand_word();
            stall_i = use_stall && (r[1:0] == 2'b00);
            ib_i    = ib;
            if (!stall_i) begin
                exp_q.push_back(ref_dispatch(ib, csr_plv_i, has_int_i));
                taken = 1'b1;
            end
        end
    endtask

    // Empty slots still carry leftover fields from the fetch side
    task automatic idle_cycles(input int n);
        instr_buffer_info_t junk;
        logic [31:0]        r;
        repeat (n) begin
            @(negedge clk);
            r                     = rand_word();
            junk                  = '0;
            junk.pc               = rand_word();
            junk.instr            = rand_word();
            junk.is_last_in_block = r[0];
            junk.ftq_id           = r[3:1];
            junk.fe_excp          = r[7:4];
            ib_i                  = junk;
            stall_i               = 1'b0;
        end
    endtask

    task automatic drain_pipe();
        idle_cycles(3);
        if (exp_q.size() != 0) begin
            $display("%0d records still missing after the pipeline drained", exp_q.size());
            abort_run();
        end
    endtask

    // Two records in flight, then a flush with stall also high
    task automatic flush_pair(input int kind);
        id_dispatch_t dropped;
        send(make_instr(kind), 4'h0, 1'b0);
        send(make_instr((kind + 5) % 24), 4'h0, 1'b0);
        @(negedge clk);
        ib_i    = '0;
        stall_i = 1'b1;
        flush_i = 1'b1;
        dropped = exp_q.pop_back();
        dropped = exp_q.pop_back();
        @(negedge clk);
        flush_i = 1'b0;
        stall_i = 1'b0;
        if (dispatch_o.instr_info.valid) begin
            $display("a record appeared on the dispatch output right after a flush");
            abort_run();
        end
    endtask

    // A record leaves at an edge without stall or flush
    initial begin : compare_proc
        id_dispatch_t held;
        id_dispatch_t want;
        forever begin
            @(negedge clk);
            held = dispatch_o;
            @(posedge clk);
            if (held.instr_info.valid && !stall_i && !flush_i) begin
                if (exp_q.size() == 0) begin
                    $display("a dispatch record arrived with no instruction outstanding");
                    abort_run();
                end else begin
                    want = exp_q.pop_front();
                    check_excp(held.excp_num, want.excp_num);
                    check_dispatch(held, want);
                end
            end else if (!held.instr_info.valid) begin
                // An empty record has every field cleared
                check_dispatch(held, '0);
            end
        end
    end

    initial begin : watchdog
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= max_cycles) begin
                $display("the run passed %0d cycles without finishing", max_cycles);
                abort_run();
            end
        end
    end

    initial begin : stimulus
        logic [31:0] w;
        logic [31:0] r;
        logic [31:0] words [$];
        ib_i      = '0;
        stall_i   = 1'b0;
        flush_i   = 1'b0;
        has_int_i = 1'b0;
        csr_plv_i = 2'd0;
        reset_i   = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        // Empty output after reset, then a two edge latency
        repeat (3) begin
            idle_cycles(1);
            if (dispatch_o.instr_info.valid) begin
                $display("the dispatch output went valid with nothing sent after reset");
                abort_run();
            end
        end
        send(make_instr(0), 4'h0, 1'b0);
        idle_cycles(1);
        if (dispatch_o.instr_info.valid) begin
            $display("the first record appeared one edge after sampling");
            abort_run();
        end
        idle_cycles(1);
        if (!dispatch_o.instr_info.valid) begin
            $display("the first record was missing two edges after sampling");
            abort_run();
        end
        drain_pipe();

        // Every supported kind at privilege 0
        for (int n = 0; n < 12; n++) begin
            for (int k = 0; k < 24; k++) begin
                send(make_instr(k), 4'h0, 1'b0);
            end
        end
        drain_pipe();

        // Words outside the subset
        repeat (100) begin
            w = rand_word();
            while (ref_aluop(w) != '0) begin
                w = rand_word();
            end
            send(w, 4'h0, 1'b0);
        end
        drain_pipe();

        // Kernel and user words at privilege 3, then the same words at 0
        for (int n = 0; n < 100; n++) begin
            words.push_back(make_instr((n % 2 == 0) ? 19 + (n / 2) % 5 : (n / 2) % 19));
        end
        csr_plv_i = 2'd3;
        foreach (words[i]) send(words[i], 4'h0, 1'b0);
        drain_pipe();
        csr_plv_i = 2'd0;
        foreach (words[i]) send(words[i], 4'h0, 1'b0);
        drain_pipe();

        // Fetch-side bits, then a pending interrupt
        for (int n = 0; n < 150; n++) begin
            r = rand_word();
            send(make_instr(n % 24), r[3:0], 1'b0);
        end
        drain_pipe();
        has_int_i = 1'b1;
        for (int n = 0; n < 50; n++) begin
            send(make_instr(n % 24), 4'h0, 1'b0);
        end
        drain_pipe();
        has_int_i = 1'b0;

        // Random stalls with periodic flushes
        for (int n = 0; n < 200; n++) begin
            send(make_instr((n * 7) % 24), 4'h0, 1'b1);
            if (n % 25 == 24) flush_pair((n / 25) % 24);
        end
        idle_cycles(3);

        if (exp_q.size() != 0) begin
            $display("%0d expected records never reached the dispatch output", exp_q.size());
            abort_run();
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

//--- src.f
hw/isa_pkg.sv
hw/core_pkg.sv
hw/decoder_3r.sv
hw/decoder_2ri12.sv
hw/decoder_long_imm.sv
hw/decoder_csr.sv
hw/id.sv
hw/stage_reg.sv
hw/id_stage.sv
sim/tb_id_stage.sv
